/* wisc_pkg.sv */
package wisc_pkg;

   localparam int DATA_W     = 16;
   localparam int REG_AW     = 3;
   localparam int DMEM_WORDS = 256;
   localparam int DMEM_AW    = $clog2(DMEM_WORDS);
   localparam int SHAMT_W    = $clog2(DATA_W);

   typedef enum logic [2:0] {
      alu_add, alu_sub, alu_and, alu_xor, alu_sll, alu_srl, alu_rol, alu_pass_b
   } alu_op_t;

   typedef enum logic [1:0] {set_seq, set_slt, set_sle, set_sco} set_sel_t;

   typedef enum logic [2:0] {
      wr_alu, wr_mem, wr_set, wr_lbi, wr_slbi, wr_link
   } wr_sel_t;

   // branch test is always on operand 1
   typedef enum logic [2:0] {br_none, br_beqz, br_bnez, br_bltz, br_bgez} br_cond_t;

   typedef struct packed {
      logic              valid;
      alu_op_t           op;
      logic [DATA_W-1:0] rd_data_1;
      logic [DATA_W-1:0] rd_data_2;
      logic [DATA_W-1:0] imm;       // already sign extended
      logic              use_imm;
      set_sel_t          set_sel;
      logic              mem_wr;
      logic              mem_en;
      logic              wr_en;
      logic [REG_AW-1:0] wr_reg;
      wr_sel_t           wr_sel;
      br_cond_t          br_cond;
      logic [DATA_W-1:0] pc_plus2;
   } id_ex_t;

   typedef struct packed {
      logic              valid;
      logic [DATA_W-1:0] alu_out;
      logic [DATA_W-1:0] store_data;
      logic              zero;
      logic              ltz;
      logic              lteq;
      logic              ofl;
      set_sel_t          set_sel;
      logic              mem_wr;
      logic              mem_en;
      logic              wr_en;
      logic [REG_AW-1:0] wr_reg;
      wr_sel_t           wr_sel;
      logic [DATA_W-1:0] lbi;
      logic [DATA_W-1:0] slbi;
      logic [DATA_W-1:0] pc_plus2;
   } ex_mem_t;

   typedef struct packed {
      logic              valid;
      logic [DATA_W-1:0] alu_out;
      logic [DATA_W-1:0] mem_data;
      logic              zero;
      logic              ltz;
      logic              lteq;
      logic              ofl;
      set_sel_t          set_sel;
      logic              wr_en;
      logic [REG_AW-1:0] wr_reg;
      wr_sel_t           wr_sel;
      logic [DATA_W-1:0] lbi;
      logic [DATA_W-1:0] slbi;
      logic [DATA_W-1:0] pc_plus2;
   } mem_wb_t;

   typedef struct packed {
      logic              cyc;
      logic              stb;
      logic              we;
      logic [DATA_W-1:0] adr;   // byte address
      logic [DATA_W-1:0] dat_w;
   } wb_req_t;

   typedef struct packed {
      logic              ack;
      logic [DATA_W-1:0] dat_r;
   } wb_rsp_t;

endpackage

/* pipe_reg.sv */
`timescale 1ns/1ps

module pipe_reg #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     en,
   input  payload_t d,
   output payload_t q
);

   // all zeros on reset, so valid drops too
   always_ff @(posedge clk) begin
      if (rst) begin
         q <= '0;
      end else if (en) begin
         q <= d;
      end
   end

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
   input  wisc_pkg::id_ex_t              id_ex,
   input  logic                          stall,
   output wisc_pkg::ex_mem_t             ex_next,
   output logic                          take_new_pc,
   output logic [wisc_pkg::DATA_W-1:0]   new_pc
);

   localparam int MSB = wisc_pkg::DATA_W - 1;

   logic [MSB:0]                   op_a;
   logic [MSB:0]                   op_b;
   logic [MSB:0]                   diff;
   logic [wisc_pkg::SHAMT_W-1:0]   shamt;
   logic [MSB:0]                   alu_res;
   logic                           ofl;
   logic                           ltz;
   logic                           zero;
   logic                           br_hit;

   assign op_a  = id_ex.rd_data_1;
   assign op_b  = id_ex.use_imm ? id_ex.imm : id_ex.rd_data_2;
   assign shamt = op_b[wisc_pkg::SHAMT_W-1:0];

   // flags always come from a - b, whatever the op
   assign diff = op_a - op_b;
   assign ofl  = (op_a[MSB] != op_b[MSB]) && (diff[MSB] != op_a[MSB]);
   assign ltz  = diff[MSB] ^ ofl;   // true signed a < b
   assign zero = (diff == '0);

   always_comb begin
      case (id_ex.op)
         wisc_pkg::alu_add:    alu_res = op_a + op_b;
         wisc_pkg::alu_sub:    alu_res = diff;
         wisc_pkg::alu_and:    alu_res = op_a & op_b;
         wisc_pkg::alu_xor:    alu_res = op_a ^ op_b;
         wisc_pkg::alu_sll:    alu_res = op_a << shamt;
         wisc_pkg::alu_srl:    alu_res = op_a >> shamt;
         wisc_pkg::alu_rol:    alu_res = (op_a << shamt) | (op_a >> (wisc_pkg::DATA_W - shamt));
         wisc_pkg::alu_pass_b: alu_res = op_b;
         default:              alu_res = op_b;
      endcase
   end

   always_comb begin
      case (id_ex.br_cond)
         wisc_pkg::br_beqz: br_hit = (op_a == '0);
         wisc_pkg::br_bnez: br_hit = (op_a != '0);
         wisc_pkg::br_bltz: br_hit = op_a[MSB];
         wisc_pkg::br_bgez: br_hit = ~op_a[MSB];
         default:           br_hit = 1'b0;
      endcase
   end

   // no redirect while memory holds the pipe
   assign take_new_pc = id_ex.valid & br_hit & ~stall;
   assign new_pc      = id_ex.pc_plus2 + id_ex.imm;

   always_comb begin
      ex_next.valid      = id_ex.valid;
      ex_next.alu_out    = alu_res;
      ex_next.store_data = id_ex.rd_data_2;
      ex_next.zero       = zero;
      ex_next.ltz        = ltz;
      ex_next.lteq       = ltz | zero;
      ex_next.ofl        = ofl;
      ex_next.set_sel    = id_ex.set_sel;
      ex_next.mem_wr     = id_ex.mem_wr;
      ex_next.mem_en     = id_ex.mem_en;
      ex_next.wr_en      = id_ex.wr_en;
      ex_next.wr_reg     = id_ex.wr_reg;
      ex_next.wr_sel     = id_ex.wr_sel;
      ex_next.lbi        = id_ex.imm;
      ex_next.slbi       = {op_a[7:0], id_ex.imm[7:0]};   // low byte moves up
      ex_next.pc_plus2   = id_ex.pc_plus2;
   end

endmodule

/* ex_mem.sv */
`timescale 1ns/1ps

module ex_mem (
   input  logic                clk,
   input  logic                rst,
   input  wisc_pkg::ex_mem_t   ex_next,
   input  logic                take_new_pc,
   input  logic                stall,
   output wisc_pkg::ex_mem_t   ex_mem_q,
   output logic                err
);

   wisc_pkg::ex_mem_t ex_d;
   logic              load_en;

   // sim aid, flags any X or Z on the inputs
   assign err = (^{clk, rst, ex_next, take_new_pc, stall} === 1'bx) ? 1'b1 : 1'b0;

   assign load_en = ~stall;

   // taken branch leaves a bubble behind it
   always_comb begin
      ex_d       = ex_next;
      ex_d.valid = ex_next.valid & ~take_new_pc;
   end

   pipe_reg #(
      .payload_t (wisc_pkg::ex_mem_t)
   ) u_ex_mem_reg (
      .clk (clk),
      .rst (rst),
      .en  (load_en),
      .d   (ex_d),
      .q   (ex_mem_q)
   );

endmodule

/* mem_stage.sv */
`timescale 1ns/1ps

module mem_stage (
   input  logic                clk,
   input  logic                rst,
   input  wisc_pkg::ex_mem_t   ex_mem_q,
   output wisc_pkg::wb_req_t   wb_req,
   input  wisc_pkg::wb_rsp_t   wb_rsp,
   output logic                stall,
   output wisc_pkg::mem_wb_t   mem_next
);

   typedef enum logic [1:0] {st_idle, st_access, st_done} mem_state_t;

   mem_state_t                    state;
   mem_state_t                    state_nxt;
   logic                          pending;
   logic                          req_on;
   logic [wisc_pkg::DATA_W-1:0]   rd_data_q;

   assign pending = ex_mem_q.valid & ex_mem_q.mem_en;

   always_comb begin
      state_nxt = state;
      case (state)
         st_idle:   if (pending) state_nxt = st_access;
         st_access: if (wb_rsp.ack) state_nxt = st_done;
         st_done:   state_nxt = st_idle;   // ex_mem moves on this edge
         default:   state_nxt = st_idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= st_idle;
      end else begin
         state <= state_nxt;
      end
   end

   always_ff @(posedge clk) begin
      if (wb_rsp.ack) begin
         rd_data_q <= wb_rsp.dat_r;
      end
   end

   // cyc/stb up as soon as the op lands, dropped in the cycle after ack
   assign req_on = pending & (state != st_done);
   assign stall  = req_on;

   assign wb_req = '{cyc:   req_on,
                     stb:   req_on,
                     we:    ex_mem_q.mem_wr,
                     adr:   ex_mem_q.alu_out,
                     dat_w: ex_mem_q.store_data};

   always_comb begin
      mem_next.valid    = ex_mem_q.valid & ~req_on;   // bubbles while waiting
      mem_next.alu_out  = ex_mem_q.alu_out;
      mem_next.mem_data = rd_data_q;
      mem_next.zero     = ex_mem_q.zero;
      mem_next.ltz      = ex_mem_q.ltz;
      mem_next.lteq     = ex_mem_q.lteq;
      mem_next.ofl      = ex_mem_q.ofl;
      mem_next.set_sel  = ex_mem_q.set_sel;
      mem_next.wr_en    = ex_mem_q.wr_en;
      mem_next.wr_reg   = ex_mem_q.wr_reg;
      mem_next.wr_sel   = ex_mem_q.wr_sel;
      mem_next.lbi      = ex_mem_q.lbi;
      mem_next.slbi     = ex_mem_q.slbi;
      mem_next.pc_plus2 = ex_mem_q.pc_plus2;
   end

endmodule

/* data_mem.sv */
`timescale 1ns/1ps

module data_mem (
   input  logic                clk,
   input  logic                rst,
   input  wisc_pkg::wb_req_t   wb_req,
   output wisc_pkg::wb_rsp_t   wb_rsp
);

   logic [wisc_pkg::DATA_W-1:0]   mem [wisc_pkg::DMEM_WORDS];
   logic [wisc_pkg::DMEM_AW-1:0]  idx;
   logic                          ack_q;
   logic [wisc_pkg::DATA_W-1:0]   rdata_q;
   logic                          hit;

   // byte address, word index from bits 8:1
   assign idx = wb_req.adr[wisc_pkg::DMEM_AW:1];
   assign hit = wb_req.cyc & wb_req.stb & ~ack_q;

   // single cycle ack, then low until stb drops and comes back
   always_ff @(posedge clk) begin
      if (rst) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= hit;
      end
   end

   always_ff @(posedge clk) begin
      if (hit) begin
         if (wb_req.we) begin
            mem[idx] <= wb_req.dat_w;   // write lands with ack
         end
         rdata_q <= mem[idx];
      end
   end

   assign wb_rsp = '{ack: ack_q, dat_r: rdata_q};

endmodule

/* writeback.sv */
`timescale 1ns/1ps

module writeback (
   input  wisc_pkg::mem_wb_t             mem_wb_q,
   output logic                          wb_en,
   output logic [wisc_pkg::REG_AW-1:0]   wb_reg,
   output logic [wisc_pkg::DATA_W-1:0]   wb_data
);

   logic set_bit;

   always_comb begin
      case (mem_wb_q.set_sel)
         wisc_pkg::set_seq: set_bit = mem_wb_q.zero;
         wisc_pkg::set_slt: set_bit = mem_wb_q.ltz;
         wisc_pkg::set_sle: set_bit = mem_wb_q.lteq;
         wisc_pkg::set_sco: set_bit = mem_wb_q.ofl;
         default:           set_bit = 1'b0;
      endcase
   end

   always_comb begin
      case (mem_wb_q.wr_sel)
         wisc_pkg::wr_alu:  wb_data = mem_wb_q.alu_out;
         wisc_pkg::wr_mem:  wb_data = mem_wb_q.mem_data;
         wisc_pkg::wr_set:  wb_data = {{(wisc_pkg::DATA_W-1){1'b0}}, set_bit};
         wisc_pkg::wr_lbi:  wb_data = mem_wb_q.lbi;
         wisc_pkg::wr_slbi: wb_data = mem_wb_q.slbi;
         wisc_pkg::wr_link: wb_data = mem_wb_q.pc_plus2;
         default:           wb_data = mem_wb_q.alu_out;
      endcase
   end

   assign wb_en  = mem_wb_q.valid & mem_wb_q.wr_en;
   assign wb_reg = mem_wb_q.wr_reg;

endmodule

/* backend_top.sv */
`timescale 1ns/1ps

module backend_top (
   input  logic                          clk,
   input  logic                          rst,
   input  wisc_pkg::id_ex_t              id_ex,
   output logic                          stall,
   output logic                          take_new_pc,
   output logic [wisc_pkg::DATA_W-1:0]   new_pc,
   output logic                          wb_en,
   output logic [wisc_pkg::REG_AW-1:0]   wb_reg,
   output logic [wisc_pkg::DATA_W-1:0]   wb_data,
   output logic                          err
);

   wisc_pkg::ex_mem_t   ex_next;
   wisc_pkg::ex_mem_t   ex_mem_q;
   wisc_pkg::mem_wb_t   mem_next;
   wisc_pkg::mem_wb_t   mem_wb_q;
   wisc_pkg::wb_req_t   wb_req;
   wisc_pkg::wb_rsp_t   wb_rsp;

   execute_stage u_ex (
      .id_ex       (id_ex),
      .stall       (stall),
      .ex_next     (ex_next),
      .take_new_pc (take_new_pc),
      .new_pc      (new_pc)
   );

   ex_mem u_ex_mem (
      .clk         (clk),
      .rst         (rst),
      .ex_next     (ex_next),
      .take_new_pc (take_new_pc),
      .stall       (stall),
      .ex_mem_q    (ex_mem_q),
      .err         (err)
   );

   mem_stage u_mem (
      .clk      (clk),
      .rst      (rst),
      .ex_mem_q (ex_mem_q),
      .wb_req   (wb_req),
      .wb_rsp   (wb_rsp),
      .stall    (stall),
      .mem_next (mem_next)
   );

   data_mem u_dmem (
      .clk    (clk),
      .rst    (rst),
      .wb_req (wb_req),
      .wb_rsp (wb_rsp)
   );

   // mem/wb loads every cycle, the memory stage sends bubbles while busy
   pipe_reg #(
      .payload_t (wisc_pkg::mem_wb_t)
   ) u_mem_wb (
      .clk (clk),
      .rst (rst),
      .en  (1'b1),
      .d   (mem_next),
      .q   (mem_wb_q)
   );

   writeback u_wb (
      .mem_wb_q (mem_wb_q),
      .wb_en    (wb_en),
      .wb_reg   (wb_reg),
      .wb_data  (wb_data)
   );

endmodule

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
   output logic clk
);

   initial begin
      clk = 1'b0;
   end

   always #20 clk = ~clk;   // 40 ns period

endmodule

/* tb_backend.sv */
`timescale 1ns/1ps

module tb_backend;

   localparam int N_RAND   = 400;
   localparam int N_INSTR  = wisc_pkg::DMEM_WORDS + N_RAND;
   localparam int WDOG_CYC = N_INSTR * 6 + 100;

   typedef struct packed {
      logic [wisc_pkg::REG_AW-1:0] wreg;
      logic [wisc_pkg::DATA_W-1:0] data;
   } wr_exp_t;

   logic                          clk;
   logic                          rst;
   wisc_pkg::id_ex_t              id_ex;
   logic                          stall;
   logic                          take_new_pc;
   logic [wisc_pkg::DATA_W-1:0]   new_pc;
   logic                          wb_en;
   logic [wisc_pkg::REG_AW-1:0]   wb_reg;
   logic [wisc_pkg::DATA_W-1:0]   wb_data;
   logic                          err;

   logic [wisc_pkg::DATA_W-1:0]   model_mem [wisc_pkg::DMEM_WORDS];
   wr_exp_t                       exp_q [$];
   int                            errors;
   int                            stall_cycles;
   integer                        seed;

   tb_clock u_clk (.clk(clk));

   backend_top UUT (
      .clk         (clk),
      .rst         (rst),
      .id_ex       (id_ex),
      .stall       (stall),
      .take_new_pc (take_new_pc),
      .new_pc      (new_pc),
      .wb_en       (wb_en),
      .wb_reg      (wb_reg),
      .wb_data     (wb_data),
      .err         (err)
   );

   function automatic logic [15:0] alu_model(input wisc_pkg::alu_op_t op,
                                             input logic [15:0] a, input logic [15:0] b);
      logic [15:0] r;
      r = a;
      case (op)
         wisc_pkg::alu_add: r = a + b;
         wisc_pkg::alu_sub: r = a - b;
         wisc_pkg::alu_and: r = a & b;
         wisc_pkg::alu_xor: r = a ^ b;
         wisc_pkg::alu_sll: r = a << b[3:0];
         wisc_pkg::alu_srl: r = a >> b[3:0];
         wisc_pkg::alu_rol: repeat (b[3:0]) r = {r[14:0], r[15]};
         default:           r = b;
      endcase
      return r;
   endfunction

   // flags from the full signed difference a - b
   function automatic logic set_model(input wisc_pkg::set_sel_t sel,
                                      input logic [15:0] a, input logic [15:0] b);
      int d;
      d = $signed(a) - $signed(b);
      case (sel)
         wisc_pkg::set_seq: return d == 0;
         wisc_pkg::set_slt: return d < 0;
         wisc_pkg::set_sle: return d <= 0;
         default:           return (d > 32767) || (d < -32768);
      endcase
   endfunction

   function automatic logic branch_model(input wisc_pkg::br_cond_t c, input logic [15:0] a);
      case (c)
         wisc_pkg::br_beqz: return a == 16'h0;
         wisc_pkg::br_bnez: return a != 16'h0;
         wisc_pkg::br_bltz: return a[15];
         wisc_pkg::br_bgez: return ~a[15];
         default:           return 1'b0;
      endcase
   endfunction

   // holds the instruction until an edge with stall low, then predicts its effect
   task automatic issue(input wisc_pkg::id_ex_t ins);
      logic [15:0] op_b;
      logic [15:0] res;
      logic        acc;
      logic        taken;
      wr_exp_t     w;
      id_ex = ins;
      acc   = 1'b0;
      taken = 1'b0;
      while (!acc) begin
         @(negedge clk);
         acc   = ~stall;
         taken = acc & ins.valid & branch_model(ins.br_cond, ins.rd_data_1);
         if (stall) stall_cycles++;
         if (take_new_pc !== taken) begin
            errors++;
            $display("Error %0t: take_new_pc is %b, expected %b", $time, take_new_pc, taken);
         end else if (taken && new_pc !== ins.pc_plus2 + ins.imm) begin
            errors++;
            $display("Error %0t: new_pc %h, expected %h", $time, new_pc,
                     ins.pc_plus2 + ins.imm);
         end
         @(posedge clk);
         #2;
      end
      op_b = ins.use_imm ? ins.imm : ins.rd_data_2;
      res  = alu_model(ins.op, ins.rd_data_1, op_b);
      if (ins.mem_en && ins.mem_wr) model_mem[res[8:1]] = ins.rd_data_2;
      if (ins.wr_en && !taken) begin
         w.wreg = ins.wr_reg;
         case (ins.wr_sel)
            wisc_pkg::wr_alu:  w.data = res;
            wisc_pkg::wr_mem:  w.data = model_mem[res[8:1]];
            wisc_pkg::wr_set:  w.data = {15'b0, set_model(ins.set_sel, ins.rd_data_1, op_b)};
            wisc_pkg::wr_lbi:  w.data = ins.imm;
            wisc_pkg::wr_slbi: w.data = (ins.rd_data_1 << 8) | {8'h00, ins.imm[7:0]};
            default:           w.data = ins.pc_plus2;
         endcase
         exp_q.push_back(w);
      end
   endtask

   task automatic random_instr(output wisc_pkg::id_ex_t ins);
      logic [31:0] r;
      int          kind;
      r    = $random(seed);
      kind = r[31:16] % 9;
      ins  = '0;
      ins.valid     = 1'b1;
      ins.use_imm   = r[0];
      ins.wr_reg    = r[3:1];
      ins.op        = wisc_pkg::alu_op_t'(r[10:8]);
      ins.set_sel   = wisc_pkg::set_sel_t'(r[12:11]);
      ins.rd_data_1 = $random(seed);
      ins.rd_data_2 = $random(seed);
      ins.imm       = $random(seed);
      ins.pc_plus2  = $random(seed);
      ins.wr_en     = 1'b1;
      case (kind)
         2:       ins.wr_sel = wisc_pkg::wr_set;
         3:       ins.wr_sel = wisc_pkg::wr_lbi;
         4:       ins.wr_sel = wisc_pkg::wr_slbi;
         5:       ins.wr_sel = wisc_pkg::wr_link;
         6, 7: begin
            ins.op     = wisc_pkg::alu_add;
            ins.mem_en = 1'b1;
            ins.mem_wr = (kind == 6);   // store, no register write
            ins.wr_en  = (kind == 7);
            ins.wr_sel = wisc_pkg::wr_mem;
         end
         8: begin
            ins.wr_en   = r[15];   // a taken branch must still leave no write
            ins.br_cond = wisc_pkg::br_cond_t'(r[14:13] + 3'd1);
         end
         default: ins.wr_sel = wisc_pkg::wr_alu;
      endcase
   endtask

   // write checker, outputs are settled at the falling edge
   always @(negedge clk) begin
      wr_exp_t w;
      if (!rst) begin
         if (err !== 1'b0) begin
            errors++;
            $display("Error %0t: err output is %b", $time, err);
         end
         if (wb_en === 1'b1 && exp_q.size() == 0) begin
            errors++;
            $display("Error %0t: unexpected write r%0d = %h", $time, wb_reg, wb_data);
         end else if (wb_en === 1'b1) begin
            w = exp_q.pop_front();
            if (wb_reg !== w.wreg || wb_data !== w.data) begin
               errors++;
               $display("Error %0t: write r%0d = %h, expected r%0d = %h", $time,
                        wb_reg, wb_data, w.wreg, w.data);
            end
         end
      end
   end

   initial begin
      #(WDOG_CYC * 40);
      $display("Timeout: run did not finish within %0d cycles", WDOG_CYC);
      $display("errors: %0d", errors);
      $display("TESTBENCH FAILED");
      $finish;
   end

   initial begin
      wisc_pkg::id_ex_t ins;
      errors       = 0;
      stall_cycles = 0;
      seed         = 32'h950f;
      rst          = 1'b1;
      id_ex        = '0;
      repeat (16) @(posedge clk);
      #2;
      rst = 1'b0;
      @(negedge clk);
      if (wb_en !== 1'b0 || stall !== 1'b0 || take_new_pc !== 1'b0) begin
         errors++;
         $display("Error %0t: outputs not idle after reset", $time);
      end
      @(posedge clk);
      #2;
      // fill every word through the bus so later loads have known data
      for (int i = 0; i < wisc_pkg::DMEM_WORDS; i++) begin
         ins           = '0;
         ins.valid     = 1'b1;
         ins.use_imm   = 1'b1;
         ins.mem_en    = 1'b1;
         ins.mem_wr    = 1'b1;
         ins.rd_data_1 = i * 2;
         ins.rd_data_2 = {i[7:0] ^ 8'ha5, ~i[7:0]};
         issue(ins);
      end
      repeat (N_RAND) begin
         random_instr(ins);
         issue(ins);
      end
      id_ex = '0;
      while (exp_q.size() != 0) @(posedge clk);
      repeat (6) @(posedge clk);   // catch any late extra write
      if (stall_cycles == 0) begin
         errors++;
         $display("stall never went high during memory accesses");
      end
      $display("errors: %0d, stall cycles seen: %0d", errors, stall_cycles);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

/* flist.f */
wisc_pkg.sv
pipe_reg.sv
execute_stage.sv
ex_mem.sv
mem_stage.sv
data_mem.sv
writeback.sv
backend_top.sv
tb_clock.sv
tb_backend.sv
